/* hdl/soc_pkg.sv */
package soc_pkg;

	// bus geometry
	localparam int BUS_WIDTH = 32;
	localparam int SEL_WIDTH = 4;
	localparam int BYTE_WIDTH = BUS_WIDTH / SEL_WIDTH;
	localparam int WORD_OFS_WIDTH = $clog2(SEL_WIDTH);

	// address map, top byte picks the slave
	localparam int REGION_MSB = 31;
	localparam int REGION_LSB = 24;
	localparam logic [BUS_WIDTH-1:0] RAM_BASE = 32'h0000_0000;
	localparam logic [BUS_WIDTH-1:0] GPIO_BASE = 32'h0100_0000;

	// on-chip RAM
	localparam int RAM_WORDS = 256;
	localparam int RAM_ADDR_WIDTH = $clog2(RAM_WORDS);

	// gpio register offsets within its region
	localparam int GPIO_WIDTH = 16;
	localparam logic [REGION_LSB-1:0] GPIO_OUT_OFS = 24'h00_0000;
	localparam logic [REGION_LSB-1:0] GPIO_IN_OFS = 24'h00_0004;

	// power-on reset stretch
	localparam int RESET_STRETCH_CYCLES = 16;
	localparam int STRETCH_CNT_WIDTH = $clog2(RESET_STRETCH_CYCLES);

	// master to slave
	typedef struct packed {
		logic [BUS_WIDTH-1:0] adr;
		logic [BUS_WIDTH-1:0] dat;
		logic [SEL_WIDTH-1:0] sel;
		logic                 we;
		logic                 cyc;
		logic                 stb;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic [BUS_WIDTH-1:0] dat;
		logic                 ack;
		logic                 err;
	} wb_rsp_t;

endpackage

/* hdl/reset_stretch.sv */
`timescale 1ns/1ps

module reset_stretch import soc_pkg::*; (
	input  logic clk,
	input  logic reset_i,
	output logic sys_reset_o,
	output logic sys_ready_o
);

	logic [STRETCH_CNT_WIDTH-1:0] cnt_q;
	logic                         stretch_q;

	// reset_i reaches the fabric at once, the stretch keeps it there
	assign sys_reset_o = reset_i | stretch_q;

	// fabric leaves reset one cycle before ready rises
	always_ff @(posedge clk) begin
		if (reset_i) begin
			cnt_q <= '0;
			stretch_q <= 1'b1;
		end else if (stretch_q) begin
			cnt_q <= cnt_q + 1'b1;
			if (cnt_q == STRETCH_CNT_WIDTH'(RESET_STRETCH_CYCLES - 2)) begin
				stretch_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			sys_ready_o <= 1'b0;
		end else begin
			sys_ready_o <= ~sys_reset_o;
		end
	end

	assert property (@(posedge clk) !reset_i && !$past(reset_i) |-> !$fell(sys_ready_o))
		else $error("sys_ready_o fell while reset_i was low");

endmodule

/* hdl/wb_decoder.sv */
`timescale 1ns/1ps

module wb_decoder import soc_pkg::*; (
	input  logic    clk,
	input  logic    reset_i,
	input  wb_req_t bus_req_i,
	output wb_rsp_t bus_rsp_o,
	output wb_req_t ram_req_o,
	input  wb_rsp_t ram_rsp_i,
	output wb_req_t gpio_req_o,
	input  wb_rsp_t gpio_rsp_i
);

	logic [REGION_MSB-REGION_LSB:0] region;
	logic                           hit_ram;
	logic                           hit_gpio;
	logic                           unmapped;
	logic                           err_q;

	assign region = bus_req_i.adr[REGION_MSB:REGION_LSB];
	assign hit_ram = (region == RAM_BASE[REGION_MSB:REGION_LSB]);
	assign hit_gpio = (region == GPIO_BASE[REGION_MSB:REGION_LSB]);
	assign unmapped = ~hit_ram & ~hit_gpio;

	// both slaves see the request, only the strobe is steered
	always_comb begin
		ram_req_o = bus_req_i;
		gpio_req_o = bus_req_i;
		ram_req_o.stb = bus_req_i.stb & hit_ram;
		gpio_req_o.stb = bus_req_i.stb & hit_gpio;
	end

	// no slave behind this region, answer err once per strobe
	always_ff @(posedge clk) begin
		if (reset_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= bus_req_i.cyc & bus_req_i.stb & unmapped & ~err_q;
		end
	end

	// address is held until ack or err, so it still selects the responder
	always_comb begin
		if (hit_ram) begin
			bus_rsp_o = ram_rsp_i;
		end else if (hit_gpio) begin
			bus_rsp_o = gpio_rsp_i;
		end else begin
			bus_rsp_o = '0;
		end
		bus_rsp_o.err = bus_rsp_o.err | err_q;
	end

	assert property (@(posedge clk) disable iff (reset_i)
			!(ram_req_o.stb && gpio_req_o.stb))
		else $error("ram and gpio strobes high together");

	// slave ack and decoder err must never collide
	assert property (@(posedge clk) disable iff (reset_i)
			!(bus_rsp_o.ack && bus_rsp_o.err))
		else $error("ack and err high together on the master port");

endmodule

/* hdl/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram import soc_pkg::*; (
	input  logic    clk,
	input  logic    reset_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic [BUS_WIDTH-1:0]      mem [RAM_WORDS];
	logic [RAM_ADDR_WIDTH-1:0] idx;
	logic                      accept;
	logic                      ack_q;
	logic [BUS_WIDTH-1:0]      dat_q;

	// word index, wraps inside the region
	assign idx = req_i.adr[WORD_OFS_WIDTH +: RAM_ADDR_WIDTH];

	// held strobe in the ack cycle is not a new access
	assign accept = ~reset_i & req_i.cyc & req_i.stb & ~ack_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			if (req_i.we) begin
				for (int i = 0; i < SEL_WIDTH; i++) begin
					if (req_i.sel[i]) begin
						mem[idx][i*BYTE_WIDTH +: BYTE_WIDTH] <=
							req_i.dat[i*BYTE_WIDTH +: BYTE_WIDTH];
					end
				end
			end else begin
				dat_q <= mem[idx];
			end
		end
	end

	assign rsp_o.dat = dat_q;
	assign rsp_o.ack = ack_q;
	assign rsp_o.err = 1'b0;

	// master must keep cyc up until it has seen the ack
	assert property (@(posedge clk) disable iff (reset_i) rsp_o.ack |-> req_i.cyc)
		else $error("ram ack without cyc");

endmodule

/* hdl/wb_gpio.sv */
`timescale 1ns/1ps

module wb_gpio import soc_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_i,
	input  wb_req_t               req_i,
	output wb_rsp_t               rsp_o,
	input  logic [GPIO_WIDTH-1:0] gpio_i,
	output logic [GPIO_WIDTH-1:0] gpio_o
);

	logic [REGION_LSB-1:0] ofs;
	logic                  accept;
	logic                  ack_q;
	logic [GPIO_WIDTH-1:0] out_q;
	logic [GPIO_WIDTH-1:0] in_q;
	logic [BUS_WIDTH-1:0]  dat_q;

	assign ofs = req_i.adr[REGION_LSB-1:0];
	assign accept = ~reset_i & req_i.cyc & req_i.stb & ~ack_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_q <= 1'b0;
			out_q <= '0;
		end else begin
			ack_q <= accept;
			// only the two low lanes reach the output register
			if (accept && req_i.we && ofs == GPIO_OUT_OFS) begin
				for (int i = 0; i < GPIO_WIDTH / BYTE_WIDTH; i++) begin
					if (req_i.sel[i]) begin
						out_q[i*BYTE_WIDTH +: BYTE_WIDTH] <=
							req_i.dat[i*BYTE_WIDTH +: BYTE_WIDTH];
					end
				end
			end
		end
	end

	// inputs sampled every cycle
	always_ff @(posedge clk) begin
		in_q <= gpio_i;
		if (accept && !req_i.we) begin
			if (ofs == GPIO_OUT_OFS) begin
				dat_q <= BUS_WIDTH'(out_q);
			end else if (ofs == GPIO_IN_OFS) begin
				dat_q <= BUS_WIDTH'(in_q);
			end else begin
				dat_q <= '0;
			end
		end
	end

	assign rsp_o.dat = dat_q;
	assign rsp_o.ack = ack_q;
	assign rsp_o.err = 1'b0;
	assign gpio_o = out_q;

endmodule

/* hdl/soc_fabric.sv */
`timescale 1ns/1ps

module soc_fabric import soc_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_i,
	input  wb_req_t               bus_req_i,
	output wb_rsp_t               bus_rsp_o,
	input  logic [GPIO_WIDTH-1:0] gpio_i,
	output logic [GPIO_WIDTH-1:0] gpio_o,
	output logic                  sys_ready_o
);

	logic    sys_reset;
	wb_req_t ram_req;
	wb_rsp_t ram_rsp;
	wb_req_t gpio_req;
	wb_rsp_t gpio_rsp;

	reset_stretch u_reset_stretch (
		.clk         (clk),
		.reset_i     (reset_i),
		.sys_reset_o (sys_reset),
		.sys_ready_o (sys_ready_o)
	);

	// everything below runs on the stretched reset
	wb_decoder u_decoder (
		.clk        (clk),
		.reset_i    (sys_reset),
		.bus_req_i  (bus_req_i),
		.bus_rsp_o  (bus_rsp_o),
		.ram_req_o  (ram_req),
		.ram_rsp_i  (ram_rsp),
		.gpio_req_o (gpio_req),
		.gpio_rsp_i (gpio_rsp)
	);

	wb_ram u_ram (
		.clk     (clk),
		.reset_i (sys_reset),
		.req_i   (ram_req),
		.rsp_o   (ram_rsp)
	);

	wb_gpio u_gpio (
		.clk     (clk),
		.reset_i (sys_reset),
		.req_i   (gpio_req),
		.rsp_o   (gpio_rsp),
		.gpio_i  (gpio_i),
		.gpio_o  (gpio_o)
	);

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o
);

	// 8 ns period, first rising edge at 4 ns
	initial begin
		clk_o = 1'b0;
		forever begin
			#4 clk_o = ~clk_o;
		end
	end

endmodule

/* tests/tb_soc_fabric.sv */
`timescale 1ns/1ps

module tb_soc_fabric import soc_pkg::*; ();

	localparam int ACCESS_LIMIT = 16;
	localparam int RANDOM_OPS = 64;

	typedef struct {
		logic                  we;
		logic [BUS_WIDTH-1:0]  adr;
		logic [BUS_WIDTH-1:0]  wdat;
		logic [SEL_WIDTH-1:0]  sel;
		logic [GPIO_WIDTH-1:0] gpio;
		logic [BUS_WIDTH-1:0]  exp_dat;
		logic                  exp_err;
		logic [GPIO_WIDTH-1:0] exp_gpio;
	} stim_t;

	logic                  clk;
	logic                  reset_i;
	wb_req_t               bus_req_i;
	wb_rsp_t               bus_rsp_o;
	logic [GPIO_WIDTH-1:0] gpio_i;
	logic [GPIO_WIDTH-1:0] gpio_o;
	logic                  sys_ready_o;

	// reference model of the slaves
	logic [BUS_WIDTH-1:0]  ram_model [RAM_WORDS];
	bit                    ram_written [RAM_WORDS];
	int                    written_q [$];
	logic [GPIO_WIDTH-1:0] gpio_model = '0;

	stim_t  stim_q [$];
	integer seed = 32'h21929658;
	int     cycle_cnt = 0;
	int     cycle_limit = 0;

	tb_clock u_clock (
		.clk_o (clk)
	);

	soc_fabric uut (
		.clk         (clk),
		.reset_i     (reset_i),
		.bus_req_i   (bus_req_i),
		.bus_rsp_o   (bus_rsp_o),
		.gpio_i      (gpio_i),
		.gpio_o      (gpio_o),
		.sys_ready_o (sys_ready_o)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	function automatic logic [BUS_WIDTH-1:0] merge_bytes(input logic [BUS_WIDTH-1:0] old_word,
			input logic [BUS_WIDTH-1:0] new_word, input logic [SEL_WIDTH-1:0] sel);
		logic [BUS_WIDTH-1:0] res;
		res = old_word;
		for (int b = 0; b < SEL_WIDTH; b++) begin
			if (sel[b]) begin
				res[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return res;
	endfunction

	// expected values are worked out as each entry is queued
	function automatic void add_entry(input logic we, input logic [BUS_WIDTH-1:0] adr,
			input logic [BUS_WIDTH-1:0] wdat, input logic [SEL_WIDTH-1:0] sel,
			input logic [GPIO_WIDTH-1:0] gpio);
		stim_t                s;
		int                   idx;
		logic [7:0]           region;
		logic [23:0]          ofs;
		logic [BUS_WIDTH-1:0] merged;
		s.we = we;
		s.adr = adr;
		s.wdat = wdat;
		s.sel = sel;
		s.gpio = gpio;
		s.exp_dat = '0;
		s.exp_err = 1'b0;
		region = adr[REGION_MSB:REGION_LSB];
		ofs = adr[REGION_LSB-1:0];
		if (region == RAM_BASE[REGION_MSB:REGION_LSB]) begin
			// word index wraps inside the region
			idx = (adr >> 2) % RAM_WORDS;
			if (we) begin
				ram_model[idx] = merge_bytes(ram_model[idx], wdat, sel);
				if (!ram_written[idx]) begin
					ram_written[idx] = 1'b1;
					written_q.push_back(idx);
				end
			end else begin
				s.exp_dat = ram_model[idx];
			end
		end else if (region == GPIO_BASE[REGION_MSB:REGION_LSB]) begin
			if (we && ofs == GPIO_OUT_OFS) begin
				merged = merge_bytes({16'h0000, gpio_model}, wdat, {2'b00, sel[1:0]});
				gpio_model = merged[GPIO_WIDTH-1:0];
			end else if (!we && ofs == GPIO_OUT_OFS) begin
				s.exp_dat = {16'h0000, gpio_model};
			end else if (!we && ofs == GPIO_IN_OFS) begin
				s.exp_dat = {16'h0000, gpio};
			end
		end else begin
			s.exp_err = 1'b1;
		end
		s.exp_gpio = gpio_model;
		stim_q.push_back(s);
	endfunction

	function automatic void build_stimulus();
		logic [BUS_WIDTH-1:0] gpio_out_adr;
		logic [BUS_WIDTH-1:0] gpio_in_adr;
		logic [BUS_WIDTH-1:0] rnd_a;
		logic [BUS_WIDTH-1:0] rnd_b;
		logic [SEL_WIDTH-1:0] sel;
		int                   idx;
		gpio_out_adr = GPIO_BASE | BUS_WIDTH'(GPIO_OUT_OFS);
		gpio_in_adr = GPIO_BASE | BUS_WIDTH'(GPIO_IN_OFS);
		// full words, the last word and a wrapped alias of word 2
		add_entry(1'b1, 32'h0000_0000, 32'h1122_3344, 4'hf, 16'h0000);
		add_entry(1'b1, 32'h0000_0004, 32'ha5a5_5a5a, 4'hf, 16'h0000);
		add_entry(1'b1, 32'h0000_03fc, 32'hdead_beef, 4'hf, 16'h0000);
		add_entry(1'b1, 32'h0000_0408, 32'h0bad_f00d, 4'hf, 16'h0000);
		add_entry(1'b0, 32'h0000_0000, '0, 4'hf, 16'h0000);
		add_entry(1'b0, 32'h0000_0004, '0, 4'hf, 16'h0000);
		add_entry(1'b0, 32'h0000_03fc, '0, 4'hf, 16'h0000);
		add_entry(1'b0, 32'h0000_0008, '0, 4'hf, 16'h0000);
		// partial lanes merge into the old word
		add_entry(1'b1, 32'h0000_0004, 32'hffee_ddcc, 4'b0101, 16'h0000);
		add_entry(1'b0, 32'h0000_0004, '0, 4'hf, 16'h0000);
		add_entry(1'b1, 32'h0000_0000, 32'h7700_0000, 4'b1000, 16'h0000);
		add_entry(1'b0, 32'h0000_0000, '0, 4'hf, 16'h0000);
		// gpio output register
		add_entry(1'b1, gpio_out_adr, 32'h1234_abcd, 4'hf, 16'h0000);
		add_entry(1'b0, gpio_out_adr, '0, 4'hf, 16'h0000);
		add_entry(1'b1, gpio_out_adr, 32'h0000_5500, 4'b0010, 16'h0000);
		add_entry(1'b0, gpio_out_adr, '0, 4'hf, 16'h0000);
		// gpio input register, writes there go nowhere
		add_entry(1'b0, gpio_in_adr, '0, 4'hf, 16'hc3e1);
		add_entry(1'b0, gpio_in_adr, '0, 4'hf, 16'h1f2e);
		add_entry(1'b1, gpio_in_adr, 32'hffff_ffff, 4'hf, 16'h1f2e);
		add_entry(1'b0, gpio_out_adr, '0, 4'hf, 16'h1f2e);
		// region 0x02 has no slave
		add_entry(1'b1, 32'h0200_0000, 32'hffff_ffff, 4'hf, 16'h0000);
		add_entry(1'b1, 32'h0200_0004, 32'hffff_ffff, 4'hf, 16'h0000);
		add_entry(1'b0, 32'h0200_0000, '0, 4'hf, 16'h0000);
		add_entry(1'b0, 32'h0000_0000, '0, 4'hf, 16'h0000);
		add_entry(1'b0, 32'h0000_0004, '0, 4'hf, 16'h0000);
		add_entry(1'b0, gpio_out_adr, '0, 4'hf, 16'h0000);
		// random ram traffic, reads only hit words already written
		for (int n = 0; n < RANDOM_OPS; n++) begin
			rnd_a = $random(seed);
			rnd_b = $random(seed);
			if (rnd_a[31] || written_q.size() == 0) begin
				idx = rnd_a[7:0];
				sel = ram_written[idx] ? rnd_a[25:22] : 4'hf;
				add_entry(1'b1, {8'h00, rnd_a[21:8], idx[7:0], 2'b00}, rnd_b, sel,
					rnd_b[31:16]);
			end else begin
				idx = written_q[rnd_a[30:8] % written_q.size()];
				add_entry(1'b0, {8'h00, rnd_a[21:8], idx[7:0], 2'b00}, '0, 4'hf,
					rnd_b[31:16]);
			end
		end
	endfunction

	task automatic check_held_in_reset(input string when_txt);
		assert (sys_ready_o === 1'b0)
			else abort_run($sformatf("mismatch sys_ready_o %s: got 0x%0h, expected 0x0",
				when_txt, sys_ready_o));
		assert (bus_rsp_o.ack === 1'b0)
			else abort_run($sformatf("mismatch bus_rsp_o.ack %s: got 0x%0h, expected 0x0",
				when_txt, bus_rsp_o.ack));
		assert (bus_rsp_o.err === 1'b0)
			else abort_run($sformatf("mismatch bus_rsp_o.err %s: got 0x%0h, expected 0x0",
				when_txt, bus_rsp_o.err));
		assert (gpio_o === '0)
			else abort_run($sformatf("mismatch gpio_o %s: got 0x%04h, expected 0x0000",
				when_txt, gpio_o));
	endtask

	// one bus cycle: strobe, wait for ack or err, then release
	task automatic run_access(input int num, input stim_t s);
		wb_req_t req;
		int      waited;
		req.adr = s.adr;
		req.dat = s.wdat;
		req.sel = s.sel;
		req.we = s.we;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		@(posedge clk);
		bus_req_i <= req;
		waited = 0;
		do begin
			@(posedge clk);
			@(negedge clk);
			waited++;
		end while (!bus_rsp_o.ack && !bus_rsp_o.err && waited < ACCESS_LIMIT);
		assert (bus_rsp_o.ack || bus_rsp_o.err)
			else abort_run($sformatf("entry %0d got neither ack nor err within %0d cycles",
				num, ACCESS_LIMIT));
		assert (waited == 1)
			else abort_run($sformatf("entry %0d answered after %0d cycles instead of one",
				num, waited));
		assert (bus_rsp_o.err === s.exp_err)
			else abort_run($sformatf("mismatch bus_rsp_o.err entry %0d: got 0x%0h, expected 0x%0h",
				num, bus_rsp_o.err, s.exp_err));
		assert (bus_rsp_o.ack === !s.exp_err)
			else abort_run($sformatf("mismatch bus_rsp_o.ack entry %0d: got 0x%0h, expected 0x%0h",
				num, bus_rsp_o.ack, !s.exp_err));
		if (!s.we && !s.exp_err) begin
			assert (bus_rsp_o.dat === s.exp_dat)
				else abort_run($sformatf(
					"mismatch bus_rsp_o.dat entry %0d: got 0x%08h, expected 0x%08h",
					num, bus_rsp_o.dat, s.exp_dat));
		end
		req.cyc = 1'b0;
		req.stb = 1'b0;
		@(posedge clk);
		bus_req_i <= req;
		@(negedge clk);
		assert (!bus_rsp_o.ack && !bus_rsp_o.err)
			else abort_run($sformatf("entry %0d: ack or err lasted longer than one cycle", num));
		assert (gpio_o === s.exp_gpio)
			else abort_run($sformatf("mismatch gpio_o entry %0d: got 0x%04h, expected 0x%04h",
				num, gpio_o, s.exp_gpio));
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		assert (cycle_cnt <= cycle_limit)
			else abort_run($sformatf("run did not finish within %0d cycles", cycle_limit));
	end

	initial begin
		wb_req_t early_req;
		bus_req_i = '0;
		gpio_i = '0;
		reset_i = 1'b1;
		build_stimulus();
		cycle_limit = stim_q.size() * 8 + 200;

		repeat (3) begin
			@(posedge clk);
			@(negedge clk);
			check_held_in_reset("while reset_i is high");
		end
		@(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		check_held_in_reset("right after reset_i release");

		// a gpio write during the stretch must be ignored
		early_req.adr = GPIO_BASE;
		early_req.dat = 32'hffff_ffff;
		early_req.sel = 4'hf;
		early_req.we = 1'b1;
		early_req.cyc = 1'b1;
		early_req.stb = 1'b1;
		for (int k = 1; k <= RESET_STRETCH_CYCLES; k++) begin
			@(posedge clk);
			if (k == 2) begin
				bus_req_i <= early_req;
			end
			if (k == 10) begin
				bus_req_i <= '0;
			end
			@(negedge clk);
			if (k < RESET_STRETCH_CYCLES) begin
				check_held_in_reset("during the reset stretch");
			end
		end
		assert (sys_ready_o === 1'b1)
			else abort_run($sformatf("mismatch sys_ready_o after %0d cycles: got 0x%0h, expected 0x1",
				RESET_STRETCH_CYCLES, sys_ready_o));

		foreach (stim_q[i]) begin
			@(posedge clk);
			gpio_i <= stim_q[i].gpio;
			run_access(i, stim_q[i]);
		end

		$display("Test OK");
		$finish;
	end

endmodule

/* files.f */
hdl/soc_pkg.sv
hdl/reset_stretch.sv
hdl/wb_decoder.sv
hdl/wb_ram.sv
hdl/wb_gpio.sv
hdl/soc_fabric.sv
tests/tb_clock.sv
tests/tb_soc_fabric.sv

/* Bender.yml */
package:
  name: soc_fabric

sources:
  - hdl/soc_pkg.sv
  - hdl/reset_stretch.sv
  - hdl/wb_decoder.sv
  - hdl/wb_ram.sv
  - hdl/wb_gpio.sv
  - hdl/soc_fabric.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_soc_fabric.sv
